// ==== Bender.yml ====
package:
  name: simd_alu

sources:
  - simd_alu_pkg.sv
  - lane_cmp_shift.sv
  - simd_alu.sv
  - op_engine.sv
  - wb_arbiter.sv
  - scratch_ram.sv
  - simd_alu_top.sv
  - target: simulation
    files:
      - simd_alu_chk.sv
      - simd_alu_tb.sv

// ==== build.f ====
simd_alu_pkg.sv
lane_cmp_shift.sv
simd_alu.sv
op_engine.sv
wb_arbiter.sv
scratch_ram.sv
simd_alu_top.sv
simd_alu_chk.sv
simd_alu_tb.sv

// ==== lane_cmp_shift.sv ====
`timescale 1ns/100ps

module lane_cmp_shift #(parameter int lane_width = 8)
(
	input logic [lane_width-1:0] a,
	input logic [lane_width-1:0] b,
	output logic ltu,
	output logic lts,
	output logic [lane_width-1:0] sra
);

	// one barrel stage per amount bit
	localparam int stages = $clog2(lane_width);

	logic carry;
	logic [lane_width-1:0] diff;
	logic sign;
	logic overflow;
	logic too_far;
	logic [lane_width-1:0] stage [stages+1];

	// a - b as a + ~b + 1, carry set means no borrow
	assign {carry, diff} = {1'b0, a} + {1'b0, ~b} + {{lane_width{1'b0}}, 1'b1};

	// borrow out means a below b unsigned
	assign ltu = ~carry;

	// overflow when signs differ and result sign flipped away from a
	assign overflow = (a[lane_width-1] ^ b[lane_width-1])
		& (a[lane_width-1] ^ diff[lane_width-1]);
	// negative flag corrected by overflow
	assign lts = diff[lane_width-1] ^ overflow;

	assign sign = a[lane_width-1];
	assign stage[0] = a;

	// stage i shifts by 2**i when amount bit i is set
	for (genvar i = 0; i < stages; i++)
	begin : g_stage
		assign stage[i+1] = b[i]
			? {{(1 << i){sign}}, stage[i][lane_width-1:(1 << i)]}
			: stage[i];
	end

	// any bit above the log stages means amount >= lane width
	assign too_far = |b[lane_width-1:stages];

	// out of range amount leaves only sign bits
	assign sra = too_far ? {lane_width{sign}} : stage[stages];

endmodule

// ==== op_engine.sv ====
`timescale 1ns/100ps

module op_engine
(
	input logic clk,
	input logic reset,
	input logic start,
	input simd_alu_pkg::alu_op_e op,
	input simd_alu_pkg::lane_size_e lane_size,
	input simd_alu_pkg::addr_t src_a,
	input simd_alu_pkg::addr_t src_b,
	input simd_alu_pkg::addr_t dst,
	output logic busy,
	output logic done,
	output logic cyc,
	output logic stb,
	output logic we,
	output simd_alu_pkg::addr_t adr,
	output simd_alu_pkg::word_t dat_w,
	input simd_alu_pkg::word_t dat_r,
	input logic ack
);

	import simd_alu_pkg::*;

	engine_state_e state;

	// latched command
	alu_op_e op_q;
	lane_size_e size_q;
	addr_t src_a_q;
	addr_t src_b_q;
	addr_t dst_q;

	// operand A and the result word
	word_t a_q;
	word_t res_q;
	word_t alu_result;

	// B comes straight off the bus during its ack
	simd_alu alu_i
	(
		.a(a_q),
		.b(dat_r),
		.op(op_q),
		.lane_size(size_q),
		.result(alu_result)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= st_idle;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start)
					begin
						state <= st_read_a;
					end
				end
				st_read_a:
				begin
					if (ack)
					begin
						state <= st_read_b;
					end
				end
				st_read_b:
				begin
					if (ack)
					begin
						state <= st_write;
					end
				end
				st_write:
				begin
					if (ack)
					begin
						state <= st_done;
					end
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		// command taken only when idle
		if (state == st_idle && start)
		begin
			op_q <= op;
			size_q <= lane_size;
			src_a_q <= src_a;
			src_b_q <= src_b;
			dst_q <= dst;
		end
		if (state == st_read_a && ack)
		begin
			a_q <= dat_r;
		end
		// result held steady while waiting on the arbiter
		if (state == st_read_b && ack)
		begin
			res_q <= alu_result;
		end
	end

	// one bus cycle spans the three transfers of a command
	assign cyc = (state == st_read_a) || (state == st_read_b) || (state == st_write);
	assign stb = cyc;
	assign we = (state == st_write);
	assign dat_w = res_q;

	always_comb
	begin
		case (state)
			st_read_a: adr = src_a_q;
			st_read_b: adr = src_b_q;
			default: adr = dst_q;
		endcase
	end

	assign busy = cyc;
	assign done = (state == st_done);

endmodule

// ==== scratch_ram.sv ====
`timescale 1ns/100ps

module scratch_ram
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input simd_alu_pkg::addr_t adr,
	input simd_alu_pkg::word_t dat_w,
	output simd_alu_pkg::word_t dat_r,
	output logic ack
);

	import simd_alu_pkg::*;

	word_t mem [ram_depth];
	logic req;

	// new request, ack low keeps it to one clock
	assign req = cyc & stb & ~ack;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack <= 1'b0;
		end
		else
		begin
			ack <= req;
		end
	end

	// data path, valid while ack is high
	always_ff @(posedge clk)
	begin
		if (req)
		begin
			if (we)
			begin
				mem[adr] <= dat_w;
			end
			dat_r <= mem[adr];
		end
	end

endmodule

// ==== simd_alu.sv ====
`timescale 1ns/100ps

module simd_alu
(
	input simd_alu_pkg::word_t a,
	input simd_alu_pkg::word_t b,
	input simd_alu_pkg::alu_op_e op,
	input simd_alu_pkg::lane_size_e lane_size,
	output simd_alu_pkg::word_t result
);

	import simd_alu_pkg::*;

	// per lane size results, index is the lane_size code
	word_t sum_v [4];
	word_t dif_v [4];
	word_t ltu_v [4];
	word_t lts_v [4];
	word_t sra_v [4];
	logic [1:0] sz;

	for (genvar s = 0; s < 4; s++)
	begin : g_size
		// 8, 16, 32, 64 bit lanes
		localparam int lw = 8 << s;
		localparam int lanes = data_width / lw;

		for (genvar l = 0; l < lanes; l++)
		begin : g_lane
			logic ltu;
			logic lts;

			lane_cmp_shift #(.lane_width(lw)) lane_i
			(
				.a(a[l*lw +: lw]),
				.b(b[l*lw +: lw]),
				.ltu(ltu),
				.lts(lts),
				.sra(sra_v[s][l*lw +: lw])
			);

			// lane sized add, carry dropped at lane top
			assign sum_v[s][l*lw +: lw] = a[l*lw +: lw] + b[l*lw +: lw];
			assign dif_v[s][l*lw +: lw] = a[l*lw +: lw] - b[l*lw +: lw];

			// flag in bit 0, rest of the lane zero
			assign ltu_v[s][l*lw +: lw] = {{(lw-1){1'b0}}, ltu};
			assign lts_v[s][l*lw +: lw] = {{(lw-1){1'b0}}, lts};
		end
	end

	assign sz = lane_size;

	always_comb
	begin
		case (op)
			op_add: result = sum_v[sz];
			op_sub: result = dif_v[sz];
			op_sltu: result = ltu_v[sz];
			op_slts: result = lts_v[sz];
			op_sra: result = sra_v[sz];
			// xor ignores lanes
			op_xor: result = a ^ b;
			default: result = '0;
		endcase
	end

endmodule

// ==== simd_alu_chk.sv ====
`timescale 1ns/100ps

module simd_alu_chk
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic other_ack,
	input logic done
);

	// a response only inside an open request
	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		ack |-> (cyc && stb))
		else $error("ack seen while cyc or stb is low");

	// single-clock pulse
	done_pulse: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done held high for more than one cycle");

	// arbiter answers one master at a time
	one_ack: assert property (@(posedge clk) disable iff (reset)
		!(ack && other_ack))
		else $error("both masters acked in the same cycle");

endmodule

// engine side, no second master here
bind op_engine simd_alu_chk engine_chk_i
(
	.clk(clk),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.other_ack(1'b0),
	.done(done)
);

// host side of the arbiter against the engine ack
bind wb_arbiter simd_alu_chk arbiter_chk_i
(
	.clk(clk),
	.reset(reset),
	.cyc(m0_cyc),
	.stb(m0_stb),
	.ack(m0_ack),
	.other_ack(m1_ack),
	.done(1'b0)
);

// ==== simd_alu_input.txt ====
# op(0 add 1 sub 2 sltu 3 slts 4 sra 5 xor) size(0 8b 1 16b 2 32b 3 64b) a b expected
0 0 80FF01027F01FF00 8001FF0201010100 0000000480020000
0 1 FFFF000180001234 0001FFFF80000001 0000000000001235
0 2 FFFFFFFF7FFFFFFF 0000000100000001 0000000080000000
0 3 FFFFFFFFFFFFFFFF 0000000000000002 0000000000000001
1 0 0001020304050607 0101010101010101 FF00010203040506
1 1 000000108000FFFF 000100100001FFFF FFFF00007FFF0000
1 2 0000000000000005 0000000100000006 FFFFFFFFFFFFFFFF
1 3 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF
2 0 8001FF007F1000FE 018000FF801001FF 0001000101000101
3 0 8001FF007F1000FE 018000FF801001FF 0100010000000101
3 2 8000000000000001 7FFFFFFFFFFFFFFF 0000000100000000
2 3 7FFFFFFFFFFFFFFF 8000000000000000 0000000000000001
4 0 807FF0408101FFC0 01010406070800FF C03FFF01FF00FFFF
4 1 80007FFFF0001234 000F000F00100004 FFFF0000FFFF0123
4 2 8765432176543210 0000000400000020 F876543200000000
4 3 8000000000000000 0000000000000040 FFFFFFFFFFFFFFFF
5 0 FFFF0000AAAA5555 0F0F0F0F55555555 F0F00F0FFFFF0000

// ==== simd_alu_pkg.sv ====
package simd_alu_pkg;

	// memory word and operand width
	localparam int data_width = 64;
	// word address width of the scratch memory
	localparam int addr_width = 4;
	// words in the scratch memory
	localparam int ram_depth = 16;

	// one memory word or one packed operand
	typedef logic [data_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;

	// lane-wise operations of the ALU
	typedef enum logic [2:0]
	{
		op_add,
		op_sub,
		op_sltu,
		op_slts,
		op_sra,
		op_xor
	} alu_op_e;

	// lane size, value is log2(lane bytes)
	typedef enum logic [1:0]
	{
		lane_8,
		lane_16,
		lane_32,
		lane_64
	} lane_size_e;

	// operation engine sequence
	typedef enum logic [2:0]
	{
		st_idle,
		st_read_a,
		st_read_b,
		st_write,
		st_done
	} engine_state_e;

endpackage

// ==== simd_alu_tb.sv ====
`timescale 1ns/100ps

module simd_alu_tb;

	import simd_alu_pkg::*;

	logic clk = 1'b0;
	logic reset;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	addr_t host_adr;
	word_t host_dat_w;
	word_t host_dat_r;
	logic host_ack;
	logic start;
	alu_op_e op;
	lane_size_e lane_size;
	addr_t src_a;
	addr_t src_b;
	addr_t dst;
	logic busy;
	logic done;

	// one entry per data-file line
	alu_op_e vec_op [$];
	lane_size_e vec_size [$];
	word_t vec_a [$];
	word_t vec_b [$];
	word_t vec_exp [$];

	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 200;
	logic engine_done;

	simd_alu_top simd_alu_top_i
	(
		.clk(clk),
		.reset(reset),
		.host_cyc(host_cyc),
		.host_stb(host_stb),
		.host_we(host_we),
		.host_adr(host_adr),
		.host_dat_w(host_dat_w),
		.host_dat_r(host_dat_r),
		.host_ack(host_ack),
		.start(start),
		.op(op),
		.lane_size(lane_size),
		.src_a(src_a),
		.src_b(src_b),
		.dst(dst),
		.busy(busy),
		.done(done)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// watchdog on the whole run
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("timeout: no ack or done within %0d cycles", cycle_limit);
			$display("tests failed");
			$finish;
		end
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// one single-word cycle on the host port, called right after a rising edge
	task automatic host_access(input logic write, input addr_t adr, input word_t wdata,
		output word_t rdata);
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		host_we <= write;
		host_adr <= adr;
		host_dat_w <= wdata;
		// waits here while the engine owns the bus
		do
			@(posedge clk);
		while (!host_ack);
		rdata = host_dat_r;
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we <= 1'b0;
		@(posedge clk);
		// ack lasts exactly one clock
		check_bit("host_ack", host_ack, 1'b0);
	endtask

	task automatic run_command(input int idx, input addr_t a_adr, input addr_t b_adr,
		input addr_t d_adr);
		start <= 1'b1;
		op <= vec_op[idx];
		lane_size <= vec_size[idx];
		src_a <= a_adr;
		src_b <= b_adr;
		dst <= d_adr;
		@(posedge clk);
		start <= 1'b0;
		@(posedge clk);
		check_bit("busy", busy, 1'b1);
		// latency depends on contention, only done counts
		while (!done)
			@(posedge clk);
	endtask

	initial
	begin
		int fd;
		string line;
		int n;
		word_t f_op;
		word_t f_size;
		word_t f_a;
		word_t f_b;
		word_t f_exp;
		word_t rd;
		word_t spare_val;
		addr_t a_adr;
		addr_t b_adr;
		addr_t d_adr;
		addr_t spare;

		void'($urandom(68));
		reset = 1'b1;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		start = 1'b0;
		op = op_add;
		lane_size = lane_8;
		src_a = '0;
		src_b = '0;
		dst = '0;
		engine_done = 1'b0;

		// op, lane size, A, B, expected per line
		fd = $fopen("simd_alu_input.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("could not open simd_alu_input.txt");
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%h %h %h %h %h", f_op, f_size, f_a, f_b, f_exp);
				if (n == 5 && line.getc(0) != "#")
				begin
					vec_op.push_back(alu_op_e'(f_op[2:0]));
					vec_size.push_back(lane_size_e'(f_size[1:0]));
					vec_a.push_back(f_a);
					vec_b.push_back(f_b);
					vec_exp.push_back(f_exp);
				end
			end
			$fclose(fd);
		end
		if (vec_op.size() == 0)
		begin
			errors++;
			$display("no test vectors found in simd_alu_input.txt");
		end
		cycle_limit = 40 * vec_op.size() + 200;

		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_bit("busy", busy, 1'b0);
		check_bit("done", done, 1'b0);

		for (int i = 0; i < vec_op.size(); i++)
		begin
			// two distinct sources, dst may alias one of them
			a_adr = addr_t'($urandom % ram_depth);
			b_adr = addr_t'(a_adr + 1 + ($urandom % (ram_depth - 1)));
			d_adr = addr_t'($urandom % ram_depth);
			spare = d_adr;
			while (spare == a_adr || spare == b_adr || spare == d_adr)
				spare = addr_t'($urandom % ram_depth);

			host_access(1'b1, a_adr, vec_a[i], rd);
			host_access(1'b1, b_adr, vec_b[i], rd);
			// memory round trip
			host_access(1'b0, a_adr, '0, rd);
			check_word("host_dat_r", rd, vec_a[i]);
			host_access(1'b0, b_adr, '0, rd);
			check_word("host_dat_r", rd, vec_b[i]);

			if (i % 2 == 0)
			begin
				run_command(i, a_adr, b_adr, d_adr);
			end
			else
			begin
				// odd lines run against a stream of host reads
				spare_val = {$urandom, $urandom};
				host_access(1'b1, spare, spare_val, rd);
				engine_done = 1'b0;
				fork
					begin
						run_command(i, a_adr, b_adr, d_adr);
						engine_done = 1'b1;
					end
					begin
						while (!engine_done)
						begin
							host_access(1'b0, spare, '0, rd);
							check_word("host_dat_r", rd, spare_val);
						end
					end
				join
			end

			host_access(1'b0, d_adr, '0, rd);
			check_word("host_dat_r (dst)", rd, vec_exp[i]);
		end

		$display("%0d tests, %0d checks, %0d errors", vec_op.size(), checks, errors);
		if (errors == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== simd_alu_top.sv ====
`timescale 1ns/100ps

module simd_alu_top
(
	input logic clk,
	input logic reset,
	input logic host_cyc,
	input logic host_stb,
	input logic host_we,
	input simd_alu_pkg::addr_t host_adr,
	input simd_alu_pkg::word_t host_dat_w,
	output simd_alu_pkg::word_t host_dat_r,
	output logic host_ack,
	input logic start,
	input simd_alu_pkg::alu_op_e op,
	input simd_alu_pkg::lane_size_e lane_size,
	input simd_alu_pkg::addr_t src_a,
	input simd_alu_pkg::addr_t src_b,
	input simd_alu_pkg::addr_t dst,
	output logic busy,
	output logic done
);

	import simd_alu_pkg::*;

	// engine master port
	logic eng_cyc;
	logic eng_stb;
	logic eng_we;
	addr_t eng_adr;
	word_t eng_dat_w;
	word_t eng_dat_r;
	logic eng_ack;

	// arbiter to memory
	logic s_cyc;
	logic s_stb;
	logic s_we;
	addr_t s_adr;
	word_t s_dat_w;
	word_t s_dat_r;
	logic s_ack;

	op_engine op_engine_i
	(
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.lane_size(lane_size),
		.src_a(src_a),
		.src_b(src_b),
		.dst(dst),
		.busy(busy),
		.done(done),
		.cyc(eng_cyc),
		.stb(eng_stb),
		.we(eng_we),
		.adr(eng_adr),
		.dat_w(eng_dat_w),
		.dat_r(eng_dat_r),
		.ack(eng_ack)
	);

	// host is master 0, engine master 1
	wb_arbiter wb_arbiter_i
	(
		.clk(clk),
		.reset(reset),
		.m0_cyc(host_cyc),
		.m0_stb(host_stb),
		.m0_we(host_we),
		.m0_adr(host_adr),
		.m0_dat_w(host_dat_w),
		.m0_dat_r(host_dat_r),
		.m0_ack(host_ack),
		.m1_cyc(eng_cyc),
		.m1_stb(eng_stb),
		.m1_we(eng_we),
		.m1_adr(eng_adr),
		.m1_dat_w(eng_dat_w),
		.m1_dat_r(eng_dat_r),
		.m1_ack(eng_ack),
		.s_cyc(s_cyc),
		.s_stb(s_stb),
		.s_we(s_we),
		.s_adr(s_adr),
		.s_dat_w(s_dat_w),
		.s_dat_r(s_dat_r),
		.s_ack(s_ack)
	);

	scratch_ram scratch_ram_i
	(
		.clk(clk),
		.reset(reset),
		.cyc(s_cyc),
		.stb(s_stb),
		.we(s_we),
		.adr(s_adr),
		.dat_w(s_dat_w),
		.dat_r(s_dat_r),
		.ack(s_ack)
	);

endmodule

// ==== wb_arbiter.sv ====
`timescale 1ns/100ps

module wb_arbiter
(
	input logic clk,
	input logic reset,
	input logic m0_cyc,
	input logic m0_stb,
	input logic m0_we,
	input simd_alu_pkg::addr_t m0_adr,
	input simd_alu_pkg::word_t m0_dat_w,
	output simd_alu_pkg::word_t m0_dat_r,
	output logic m0_ack,
	input logic m1_cyc,
	input logic m1_stb,
	input logic m1_we,
	input simd_alu_pkg::addr_t m1_adr,
	input simd_alu_pkg::word_t m1_dat_w,
	output simd_alu_pkg::word_t m1_dat_r,
	output logic m1_ack,
	output logic s_cyc,
	output logic s_stb,
	output logic s_we,
	output simd_alu_pkg::addr_t s_adr,
	output simd_alu_pkg::word_t s_dat_w,
	input simd_alu_pkg::word_t s_dat_r,
	input logic s_ack
);

	// one-hot current owner, bit 1 is master 1
	logic [1:0] grant;
	// master 1 had the bus most recently
	logic last;
	logic hold_m0;
	logic hold_m1;
	logic pick_m1;
	logic sel_m1;

	// owner keeps the bus until its cyc drops
	assign hold_m0 = grant[0] & m0_cyc;
	assign hold_m1 = grant[1] & m1_cyc;
	// free bus, on a tie the one not served last wins
	assign pick_m1 = m1_cyc & (~m0_cyc | ~last);
	assign sel_m1 = hold_m1 | (~hold_m0 & pick_m1);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			grant <= 2'b00;
			// so the host wins the first tie
			last <= 1'b1;
		end
		else
		begin
			grant <= {sel_m1 & m1_cyc, ~sel_m1 & m0_cyc};
			if (!hold_m0 && !hold_m1 && (m0_cyc || m1_cyc))
			begin
				last <= sel_m1;
			end
		end
	end

	// request path muxes
	assign s_cyc = sel_m1 ? m1_cyc : m0_cyc;
	assign s_stb = sel_m1 ? m1_stb : m0_stb;
	assign s_we = sel_m1 ? m1_we : m0_we;
	assign s_adr = sel_m1 ? m1_adr : m0_adr;
	assign s_dat_w = sel_m1 ? m1_dat_w : m0_dat_w;

	// response only to the selected master, the other waits
	assign m0_ack = ~sel_m1 & s_ack;
	assign m1_ack = sel_m1 & s_ack;
	assign m0_dat_r = sel_m1 ? '0 : s_dat_r;
	assign m1_dat_r = sel_m1 ? s_dat_r : '0;

endmodule
